// File: hdl/cdc_defines.svh
`ifndef CDC_DEFINES_SVH
`define CDC_DEFINES_SVH

// bits carried by one data beat
`define CDC_DATA_WIDTH 16

// memory address bits, the depth is 2**CDC_ADDR_WIDTH words
// the gray pointer logic relies on a power-of-two depth
`define CDC_ADDR_WIDTH 4

// free words kept when rx_tready drops
// covers the registered ready and the beat held in the write register
`define CDC_ALMOST_FULL_MARGIN 4

`endif

// File: hdl/cdc_pkg.sv
`default_nettype none

`include "cdc_defines.svh"

package cdc_pkg;

    typedef logic [`CDC_DATA_WIDTH-1:0] data_t;     // one data beat
    typedef logic [`CDC_ADDR_WIDTH-1:0] addr_t;     // memory address
    typedef logic [`CDC_ADDR_WIDTH:0]   ptr_t;      // address plus wrap bit

    // write request into the dual-port memory
    typedef struct packed {
        logic  enable;
        addr_t address;
        data_t data;
    } ram_write_t;

    typedef enum logic [0:0] {
        READ_IDLE,
        READ_DATA
    } read_state_t;

    function automatic ptr_t bin_to_gray(ptr_t bin);
        return bin ^ (bin >> 1);
    endfunction

    function automatic ptr_t gray_to_bin(ptr_t gray);
        ptr_t bin;
        bin[$bits(ptr_t)-1] = gray[$bits(ptr_t)-1];    // msb is shared
        for (int i = $bits(ptr_t) - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

endpackage

`default_nettype wire

// File: hdl/cdc_dual_port_ram.sv
`default_nettype none

`include "cdc_defines.svh"

module cdc_dual_port_ram
    import cdc_pkg::*;
(
    input  wire             rx_aclk,
    input  wire             tx_aclk,
    input  wire ram_write_t ram_write,
    input  wire             rd_en,
    input  wire addr_t      rd_addr,
    output data_t           rd_data
);

    localparam int depth = 1 << `CDC_ADDR_WIDTH;

    data_t mem [depth];     // storage array, contents undefined after reset

    // write port, rx domain
    always_ff @(posedge rx_aclk) begin
        if (ram_write.enable) begin
            mem[ram_write.address] <= ram_write.data;
        end
    end

    // registered read port in the tx domain
    // rd_data holds its value while rd_en is low
    always_ff @(posedge tx_aclk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// File: hdl/cdc_write_side.sv
`default_nettype none

`include "cdc_defines.svh"

module cdc_write_side
    import cdc_pkg::*;
(
    input  wire        rx_aclk,
    input  wire        areset_n,
    input  wire        rx_tvalid,
    input  wire data_t rx_tdata,
    output logic       rx_tready,
    input  wire ptr_t  rd_ptr_gray,
    output ptr_t       wr_ptr_gray,
    output ram_write_t ram_write
);

    localparam int depth = 1 << `CDC_ADDR_WIDTH;
    localparam ptr_t almost_full_level = ptr_t'(depth - `CDC_ALMOST_FULL_MARGIN);

    logic  accept;
    logic  write_enable;
    data_t write_data;
    ptr_t  wr_ptr_bin;
    ptr_t  wr_ptr_next;
    ptr_t  rd_ptr_gray_meta;
    ptr_t  rd_ptr_gray_sync;
    ptr_t  rd_ptr_bin_sync;
    ptr_t  used;
    logic  almost_full;

    always_comb accept = rx_tvalid && rx_tready;

    // input register, the beat goes to memory on the next edge
    always_ff @(posedge rx_aclk or negedge areset_n) begin
        if (!areset_n) begin
            write_enable <= 1'b0;
        end
        else begin
            write_enable <= accept;
        end
    end

    always_ff @(posedge rx_aclk) begin
        if (accept) begin
            write_data <= rx_tdata;
        end
    end

    always_comb wr_ptr_next = wr_ptr_bin + ptr_t'(1);

    // pointer moves on the same edge as the memory write,
    // so the read side never sees a word before it is stored
    always_ff @(posedge rx_aclk or negedge areset_n) begin
        if (!areset_n) begin
            wr_ptr_bin  <= '0;
            wr_ptr_gray <= '0;
        end
        else if (write_enable) begin
            wr_ptr_bin  <= wr_ptr_next;
            wr_ptr_gray <= bin_to_gray(wr_ptr_next);
        end
    end

    always_comb begin
        ram_write.enable  = write_enable;
        ram_write.address = addr_t'(wr_ptr_bin);     // drop the wrap bit
        ram_write.data    = write_data;
    end

    // read pointer into rx domain, two flops
    always_ff @(posedge rx_aclk or negedge areset_n) begin
        if (!areset_n) begin
            rd_ptr_gray_meta <= '0;
            rd_ptr_gray_sync <= '0;
        end
        else begin
            rd_ptr_gray_meta <= rd_ptr_gray;
            rd_ptr_gray_sync <= rd_ptr_gray_meta;
        end
    end

    always_comb rd_ptr_bin_sync = gray_to_bin(rd_ptr_gray_sync);

    // stale read pointer only overstates the fill level
    always_comb used = wr_ptr_bin - rd_ptr_bin_sync;
    always_comb almost_full = (used >= almost_full_level);

    always_ff @(posedge rx_aclk or negedge areset_n) begin
        if (!areset_n) begin
            rx_tready <= 1'b0;
        end
        else begin
            rx_tready <= !almost_full;
        end
    end

endmodule

`default_nettype wire

// File: hdl/cdc_read_side.sv
`default_nettype none

module cdc_read_side
    import cdc_pkg::*;
(
    input  wire        tx_aclk,
    input  wire        areset_n,
    input  wire        tx_tready,
    output logic       tx_tvalid,
    output data_t      tx_tdata,
    input  wire ptr_t  wr_ptr_gray,
    output ptr_t       rd_ptr_gray,
    output logic       rd_en,
    output addr_t      rd_addr,
    input  wire data_t rd_data
);

    read_state_t state;
    ptr_t        rd_ptr_bin;
    ptr_t        rd_ptr_next;
    ptr_t        wr_ptr_gray_meta;
    ptr_t        wr_ptr_gray_sync;
    logic        empty;

    // write pointer into tx domain, two flops
    always_ff @(posedge tx_aclk or negedge areset_n) begin
        if (!areset_n) begin
            wr_ptr_gray_meta <= '0;
            wr_ptr_gray_sync <= '0;
        end
        else begin
            wr_ptr_gray_meta <= wr_ptr_gray;
            wr_ptr_gray_sync <= wr_ptr_gray_meta;
        end
    end

    // both pointers gray coded, so compare directly
    always_comb empty = (rd_ptr_gray == wr_ptr_gray_sync);

    always_ff @(posedge tx_aclk or negedge areset_n) begin
        if (!areset_n) begin
            state <= READ_IDLE;
        end
        else begin
            case (state)
                READ_IDLE: begin
                    if (!empty) begin
                        state <= READ_DATA;     // data arrives with this edge
                    end
                end
                READ_DATA: begin
                    if (tx_tready && empty) begin
                        state <= READ_IDLE;
                    end
                end
                default: begin
                    state <= READ_IDLE;
                end
            endcase
        end
    end

    // output register holds while the sink stalls
    always_comb begin
        case (state)
            READ_IDLE: rd_en = !empty;
            READ_DATA: rd_en = !empty && tx_tready;    // refill on transfer
            default:   rd_en = 1'b0;
        endcase
    end

    always_comb rd_ptr_next = rd_ptr_bin + ptr_t'(1);

    always_ff @(posedge tx_aclk or negedge areset_n) begin
        if (!areset_n) begin
            rd_ptr_bin  <= '0;
            rd_ptr_gray <= '0;
        end
        else if (rd_en) begin
            rd_ptr_bin  <= rd_ptr_next;
            rd_ptr_gray <= bin_to_gray(rd_ptr_next);
        end
    end

    always_comb rd_addr = addr_t'(rd_ptr_bin);

    always_comb tx_tvalid = (state == READ_DATA);
    always_comb tx_tdata = rd_data;     // memory output register feeds tx directly

endmodule

`default_nettype wire

// File: hdl/cdc_stream_fifo.sv
`default_nettype none

module cdc_stream_fifo
    import cdc_pkg::*;
(
    input  wire        areset_n,
    input  wire        rx_aclk,
    input  wire        rx_tvalid,
    input  wire data_t rx_tdata,
    output logic       rx_tready,
    input  wire        tx_aclk,
    input  wire        tx_tready,
    output logic       tx_tvalid,
    output data_t      tx_tdata
);

    ram_write_t ram_write;      // rx domain write request
    ptr_t       wr_ptr_gray;    // crosses to tx
    ptr_t       rd_ptr_gray;    // crosses to rx
    logic       rd_en;
    addr_t      rd_addr;
    data_t      rd_data;

    cdc_write_side write_side (
        .rx_aclk     (rx_aclk),
        .areset_n    (areset_n),
        .rx_tvalid   (rx_tvalid),
        .rx_tdata    (rx_tdata),
        .rx_tready   (rx_tready),
        .rd_ptr_gray (rd_ptr_gray),
        .wr_ptr_gray (wr_ptr_gray),
        .ram_write   (ram_write)
    );

    cdc_dual_port_ram ram (
        .rx_aclk   (rx_aclk),
        .tx_aclk   (tx_aclk),
        .ram_write (ram_write),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    // output state machine and read pointer
    cdc_read_side read_side (
        .tx_aclk     (tx_aclk),
        .areset_n    (areset_n),
        .tx_tready   (tx_tready),
        .tx_tvalid   (tx_tvalid),
        .tx_tdata    (tx_tdata),
        .wr_ptr_gray (wr_ptr_gray),
        .rd_ptr_gray (rd_ptr_gray),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data)
    );

endmodule

`default_nettype wire

// File: sim/cdc_stream_fifo_tb.sv
`default_nettype none

`include "cdc_defines.svh"

module cdc_stream_fifo_tb
    import cdc_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int rx_period    = 100;
    localparam int tx_period    = 130;
    localparam int drive_delay  = 10;
    localparam int depth        = 1 << `CDC_ADDR_WIDTH;
    localparam int stream_beats = 300;
    localparam int fill_cycles  = 60;     // rx cycles of continuous offer with the sink stalled
    localparam int drain_limit  = 400;    // tx cycles allowed for the fifo to empty
    localparam int total_beats  = 2 * stream_beats + depth;
    localparam int watchdog_ns  = total_beats * 20 * tx_period + 200 * tx_period;

    localparam logic [31:0] lcg_seed = 32'd96905;

    typedef enum logic [1:0] {
        SINK_STALL,
        SINK_READY,
        SINK_RANDOM
    } sink_mode_t;

    logic       rx_aclk;
    logic       tx_aclk;
    logic       areset_n;
    logic       rx_tvalid;
    data_t      rx_tdata;
    logic       rx_tready;
    logic       tx_tready;
    logic       tx_tvalid;
    data_t      tx_tdata;

    sink_mode_t  sink_mode;
    logic [31:0] data_state;      // source data generator
    logic [31:0] rx_ctrl_state;   // rx_tvalid pattern
    logic [31:0] tx_ctrl_state;   // tx_tready pattern
    bit          have_word;       // rx_tdata holds a beat not yet accepted
    int          sent_count;
    int          recv_count;
    logic        prev_valid;
    logic        prev_ready;
    data_t       prev_data;

    cdc_stream_fifo uut (
        .areset_n  (areset_n),
        .rx_aclk   (rx_aclk),
        .rx_tvalid (rx_tvalid),
        .rx_tdata  (rx_tdata),
        .rx_tready (rx_tready),
        .tx_aclk   (tx_aclk),
        .tx_tready (tx_tready),
        .tx_tvalid (tx_tvalid),
        .tx_tdata  (tx_tdata)
    );

    initial begin
        rx_aclk = 1'b0;
        forever #(rx_period / 2) rx_aclk = ~rx_aclk;
    end

    initial begin
        tx_aclk = 1'b0;
        forever #(tx_period / 2) tx_aclk = ~tx_aclk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // 0..99 from the upper half of the state
    function automatic int percent_draw(input logic [31:0] state);
        int value;
        value = int'(state >> 16);
        return value % 100;
    endfunction

    // n-th beat of the source stream, rebuilt from the seed
    function automatic data_t expected_word(input int index);
        logic [31:0] state;
        state = lcg_seed;
        for (int i = 0; i <= index; i++) begin
            state = lcg_step(state);
        end
        return data_t'(state >> 16);
    endfunction

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_data(input string name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("error %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            report_failure($sformatf("error %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // one rx cycle, a held beat keeps valid until it is taken
    task automatic rx_cycle(input int valid_pct, output bit accepted);
        @(posedge rx_aclk);
        #drive_delay;
        if (!have_word) begin
            data_state = lcg_step(data_state);
            rx_tdata   = data_t'(data_state >> 16);
            rx_tvalid  = 1'b0;
            have_word  = 1'b1;
        end
        if (!rx_tvalid) begin
            rx_ctrl_state = lcg_step(rx_ctrl_state);
            rx_tvalid     = percent_draw(rx_ctrl_state) < valid_pct;
        end
        @(negedge rx_aclk);
        accepted = rx_tvalid && rx_tready;    // transfer happens on the coming edge
        if (accepted) begin
            have_word = 1'b0;
            sent_count++;
        end
    endtask

    task automatic rx_idle();
        @(posedge rx_aclk);
        #drive_delay;
        rx_tvalid = 1'b0;
    endtask

    task automatic send_beats(input int count, input int valid_pct);
        int  done;
        bit  accepted;
        done = 0;
        while (done < count) begin
            rx_cycle(valid_pct, accepted);
            if (accepted) begin
                done++;
            end
        end
        rx_idle();
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (recv_count < sent_count && cycles < drain_limit) begin
            @(posedge tx_aclk);
            cycles++;
        end
        if (recv_count != sent_count) begin
            report_failure("beats lost: fewer received than sent");
        end
    endtask

    // sink side, tx_tready per mode
    initial begin
        forever begin
            @(posedge tx_aclk);
            #drive_delay;
            case (sink_mode)
                SINK_READY: begin
                    tx_tready = 1'b1;
                end
                SINK_RANDOM: begin
                    tx_ctrl_state = lcg_step(tx_ctrl_state);
                    tx_tready     = percent_draw(tx_ctrl_state) < 50;
                end
                default: begin
                    tx_tready = 1'b0;
                end
            endcase
        end
    end

    // scoreboard, sampled midway between tx edges
    always @(negedge tx_aclk) begin
        if (areset_n) begin
            if (prev_valid && !prev_ready) begin
                check_flag("tx_tvalid", 1'b1, tx_tvalid);    // stalled beat must stay
                check_data("tx_tdata", prev_data, tx_tdata);
            end
            if (tx_tvalid && tx_tready) begin
                if (recv_count >= sent_count) begin
                    report_failure("extra beat: more received than sent");
                end
                check_data("tx_tdata", expected_word(recv_count), tx_tdata);
                recv_count++;
            end
        end
        prev_valid = tx_tvalid;
        prev_ready = tx_tready;
        prev_data  = tx_tdata;
    end

    initial begin
        #(watchdog_ns);
        report_failure($sformatf("timeout: run still going after %0d ns", watchdog_ns));
    end

    initial begin
        bit accepted;
        int fill_count;

        areset_n      = 1'b0;
        rx_tvalid     = 1'b0;
        rx_tdata      = '0;
        tx_tready     = 1'b0;
        sink_mode     = SINK_STALL;
        data_state    = lcg_seed;
        rx_ctrl_state = lcg_seed;
        tx_ctrl_state = lcg_seed;
        have_word     = 1'b0;
        sent_count    = 0;
        recv_count    = 0;
        prev_valid    = 1'b0;
        prev_ready    = 1'b0;
        prev_data     = '0;

        // outputs low in reset
        @(posedge rx_aclk);
        @(negedge rx_aclk);
        check_flag("rx_tready", 1'b0, rx_tready);
        check_flag("tx_tvalid", 1'b0, tx_tvalid);
        @(posedge rx_aclk);
        #drive_delay;
        areset_n = 1'b1;
        @(negedge rx_aclk);     // values seen by the first edge after release
        check_flag("rx_tready", 1'b0, rx_tready);
        check_flag("tx_tvalid", 1'b0, tx_tvalid);
        @(negedge rx_aclk);
        check_flag("rx_tready", 1'b1, rx_tready);
        repeat (20) begin
            @(negedge tx_aclk);
            check_flag("tx_tvalid", 1'b0, tx_tvalid);
        end

        $display("streaming with the sink always ready");
        sink_mode = SINK_READY;
        send_beats(stream_beats, 50);
        wait_drained();

        $display("streaming with random back-pressure");
        sink_mode = SINK_RANDOM;
        send_beats(stream_beats, 50);
        wait_drained();

        // fill with the sink stalled, then drain
        $display("fill and drain");
        sink_mode = SINK_STALL;
        repeat (2) @(posedge tx_aclk);
        fill_count = 0;
        repeat (fill_cycles) begin
            rx_cycle(100, accepted);
            if (accepted) begin
                fill_count++;
            end
            if (fill_count > depth) begin
                report_failure("overflow: more beats accepted than the fifo can hold");
            end
        end
        check_flag("rx_tready", 1'b0, rx_tready);
        check_flag("tx_tvalid", 1'b1, tx_tvalid);
        $display("fifo took %0d beats before rx_tready fell", fill_count);
        sink_mode = SINK_READY;
        while (have_word) begin
            rx_cycle(100, accepted);      // finish the beat still on offer
        end
        rx_idle();
        wait_drained();
        repeat (20) begin
            @(negedge tx_aclk);
            check_flag("tx_tvalid", 1'b0, tx_tvalid);
        end

        if (recv_count == sent_count) begin
            $display("sim passed");
            $finish;
        end
        else begin
            report_failure("beats lost: fewer received than sent");
        end
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+hdl
hdl/cdc_pkg.sv
hdl/cdc_dual_port_ram.sv
hdl/cdc_write_side.sv
hdl/cdc_read_side.sv
hdl/cdc_stream_fifo.sv
sim/cdc_stream_fifo_tb.sv

// File: run.sh
#!/bin/sh
# build the testbench with verilator and run it from the project root
# the exit status of the run is the result
cd "$(dirname "$0")" &&
verilator --binary -j 0 \
    --top-module cdc_stream_fifo_tb \
    -f list.f \
    -o cdc_stream_fifo_sim &&
./obj_dir/cdc_stream_fifo_sim ||
{ echo "build or simulation did not complete cleanly" >&2; exit 1; }
